/* pid_controller.f */
+incdir+rtl
rtl/pid_pkg.sv
rtl/loop_cfg_if.sv
rtl/dac_word_if.sv
rtl/adc_reader.sv
rtl/oversample_filter.sv
rtl/pid_core.sv
rtl/dac_instr_queue.sv
rtl/dac_controller.sv
rtl/pid_controller.sv
verif/pid_controller_properties.sv
verif/pid_controller_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pid_controller testbench with verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module pid_controller_tb -f pid_controller.f > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vpid_controller_tb +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "simulator returned a failing status"
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* verif/pid_controller_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module pid_controller_tb;

localparam int PHASE_CYC = 40;	// adc cycles per phase
localparam int N_PHASE = 6;
localparam int TIMEOUT = N_PHASE * PHASE_CYC * `ADC_CYCLE + 2000;	// margin for reset and drain
localparam int BUSY_LEN = 20;	// conversion time of the adc model

// dut ports
logic               clk50;
logic               rst_n;
logic               adc_busy;
logic               adc_data_a;
logic               adc_data_b;
logic               adc_convst;
logic               adc_n_cs;
logic               adc_sclk;
logic               dac_nsync;
logic               dac_sclk;
logic               dac_din;
pid_pkg::sample_t   setpoint;
pid_pkg::coef_t     p_coef;
pid_pkg::coef_t     i_coef;
pid_pkg::coef_t     d_coef;
logic [`W_OSM-1:0]  osm;
logic               lock_en;
pid_pkg::dac_code_t out_min;
pid_pkg::dac_code_t out_max;
pid_pkg::dac_code_t out_init;

int errors = 0;
int frames = 0;
int readouts = 0;	// adc readouts started by the dut
int cycles = 0;
int seed = 32'h3ce7_7008;

// adc model
int               busy_cnt;
int               sclk_pulses;
pid_pkg::sample_t shift_a;
pid_pkg::sample_t shift_b;
logic             convst_q;
logic             n_cs_q;
logic             adc_sclk_q;

// dac model
logic [31:0] frame;
int          nbits;
logic        dac_sclk_q;
logic        nsync_q;

// reference model state per channel
longint      acc [`N_CHAN];		// filter sum
int          cnt [`N_CHAN];		// samples in the current window
longint      integ [`N_CHAN];
longint      prev_err [`N_CHAN];
logic [15:0] exp_q [`N_CHAN][$];	// codes still to come per dac channel

pid_controller UUT (.*);

initial begin
	clk50 = 1'b0;
	forever #5 clk50 = !clk50;
end

//////////////////////////////
// checks and reference model
//////////////////////////////

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	assert (actual === expected) else begin
		errors++;
		$display("error %s expected %h got %h", name, expected, actual);
	end
endtask

function automatic pid_pkg::sample_t draw_sample();
	int r;
	r = $random(seed) % 4097;	// -4096 .. 4096
	return pid_pkg::sample_t'(r);
endfunction

// oversample, pid and clamp rules applied to each sample as it is read out
task automatic model_sample(input int ch, input pid_pkg::sample_t s);
	longint sum;
	longint avg;
	longint err;
	longint diff;
	longint pid;
	logic [15:0] code;
	sum = acc[ch] + longint'(s);
	if (!lock_en) begin	// unlocked loop forgets its history
		integ[ch] = 0;
		prev_err[ch] = 0;
	end
	if (cnt[ch] < (1 << osm) - 1) begin
		acc[ch] = sum;
		cnt[ch]++;
	end else begin	// window of 2^osm samples complete
		acc[ch] = 0;
		cnt[ch] = 0;
		avg = sum >>> osm;
		if (!lock_en) code = out_init;
		else begin
			err = longint'(setpoint) - avg;
			diff = err - prev_err[ch];
			integ[ch] += err;
			prev_err[ch] = err;
			pid = longint'(p_coef) * err + longint'(i_coef) * integ[ch];
			pid = pid + longint'(d_coef) * diff + longint'(out_init);
			if (pid < longint'(out_min)) code = out_min;
			else if (pid > longint'(out_max)) code = out_max;
			else code = pid[15:0];
		end
		exp_q[ch].push_back(code);
	end
endtask

task automatic check_frame();
	logic [3:0] addr;
	logic [15:0] exp_code;
	addr = frame[23:20];
	frames++;
	check_value("dac_sclk falling edge count", 32, nbits);
	check_value("dac_din frame prefix", 4'h0, frame[31:28]);
	check_value("dac_din frame command", `DAC_CMD, frame[27:24]);
	check_value("dac_din frame feature", 4'h0, frame[3:0]);
	assert (addr < `N_CHAN) else begin
		errors++;
		$display("frame addressed to dac channel %0d, which no loop drives", addr);
	end
	if (addr < `N_CHAN) begin
		assert (exp_q[addr].size() != 0) else begin
			errors++;
			$display("frame on dac channel %0d with no code left to expect", addr);
		end
		if (exp_q[addr].size() != 0) begin
			exp_code = exp_q[addr].pop_front();
			check_value("dac_din frame code", exp_code, frame[19:4]);
		end
	end
endtask

task automatic finish_run(input bit timed_out);
	int prop_fails;
	prop_fails = UUT.props.fail_cnt;
	$display("summary: %0d failed checks, %0d failed properties, %0d frames checked",
		errors, prop_fails, frames);
	if (!timed_out && errors == 0 && prop_fails == 0) $display("Finished with no errors");
	else $display("Finished with errors");
	$finish;
endtask

// config changes right after a convst rise when no result is in flight
task automatic run_phase(input logic [`W_OSM-1:0] osm_val, input logic lock, input int p,
	input int i, input int d, input int sp);
	osm = osm_val;
	lock_en = lock;
	p_coef = pid_pkg::coef_t'(p);
	i_coef = pid_pkg::coef_t'(i);
	d_coef = pid_pkg::coef_t'(d);
	setpoint = pid_pkg::sample_t'(sp);
	repeat (PHASE_CYC) @(posedge adc_convst);
	@(posedge clk50);
	#1;
endtask

//////////////////////////////
// adc and dac models
//////////////////////////////

always @(posedge clk50) begin
	#1;
	if (!rst_n) begin
		adc_busy = 1'b0;
		busy_cnt = 0;
	end else begin
		if (adc_convst && !convst_q) begin	// conversion starts
			adc_busy = 1'b1;
			busy_cnt = BUSY_LEN;
		end else if (busy_cnt > 0) begin
			busy_cnt--;
			if (busy_cnt == 0) adc_busy = 1'b0;
		end
		if (!adc_n_cs && n_cs_q) begin	// readout starts and the msb goes out at once
			readouts++;
			shift_a = draw_sample();
			shift_b = draw_sample();
			model_sample(0, shift_a);
			model_sample(1, shift_b);
			adc_data_a = shift_a[`W_SAMPLE-1];
			adc_data_b = shift_b[`W_SAMPLE-1];
			sclk_pulses = 0;
		end else if (!adc_n_cs && adc_sclk_q && !adc_sclk) begin
			shift_a = shift_a << 1;	// next bit after each falling sclk
			shift_b = shift_b << 1;
			adc_data_a = shift_a[`W_SAMPLE-1];
			adc_data_b = shift_b[`W_SAMPLE-1];
		end
		if (!adc_n_cs && adc_sclk && !adc_sclk_q) sclk_pulses++;
		if (adc_n_cs && !n_cs_q) check_value("adc_sclk pulse count", `W_SAMPLE, sclk_pulses);
	end
	convst_q = adc_convst;
	n_cs_q = adc_n_cs;
	adc_sclk_q = adc_sclk;
end

// dac latches din on falling sclk
always @(posedge clk50) begin
	#1;
	if (rst_n) begin
		if (!dac_nsync && nsync_q) nbits = 0;
		if (!dac_nsync && dac_sclk_q && !dac_sclk) begin
			frame = {frame[30:0], dac_din};
			nbits++;
		end
		if (dac_nsync && !nsync_q) check_frame();
	end
	dac_sclk_q = dac_sclk;
	nsync_q = dac_nsync;
end

always @(posedge clk50) begin
	cycles++;
	if (cycles >= TIMEOUT) begin
		$display("timeout after %0d clock cycles, the stimulus did not complete", cycles);
		finish_run(1'b1);
	end
end

//////////////////////////////
// stimulus
//////////////////////////////

initial begin
	rst_n = 1'b0;
	adc_busy = 1'b0;
	adc_data_a = 1'b0;
	adc_data_b = 1'b0;
	setpoint = '0;
	p_coef = '0;
	i_coef = '0;
	d_coef = '0;
	osm = '0;
	lock_en = 1'b0;
	out_min = 16'd1000;
	out_max = 16'd64000;
	out_init = 16'h8000;	// mid scale
	convst_q = 1'b0;
	n_cs_q = 1'b1;
	adc_sclk_q = 1'b0;
	dac_sclk_q = 1'b0;
	nsync_q = 1'b1;
	repeat (5) @(posedge clk50);
	#1;
	assert (adc_convst === 1'b0 && adc_sclk === 1'b0 && dac_sclk === 1'b0 &&
		adc_n_cs === 1'b1 && dac_nsync === 1'b1) else begin
		errors++;
		$display("adc and dac outputs are not idle after reset");
	end
	rst_n = 1'b1;
	run_phase(3'd0, 1'b0, 0, 0, 0, 0);			// unlocked with out_init every sample
	run_phase(3'd0, 1'b1, 3, 0, 0, 500);		// proportional only
	run_phase(3'd2, 1'b0, 0, 0, 0, 0);			// unlocked with one frame per 4 samples
	run_phase(3'd2, 1'b1, 1, 2, 1, -300);		// full pid with the integral from zero
	run_phase(3'd0, 1'b1, 100, 0, 0, 20000);	// saturates at out_max
	run_phase(3'd0, 1'b1, 100, 0, 0, -20000);	// saturates at out_min
	// last frames end well before the next readout
	@(posedge adc_convst);
	repeat (10) @(posedge clk50);
	#1;
	// one readout per conversion period
	assert (readouts == N_PHASE * PHASE_CYC) else begin
		errors++;
		$display("the adc was read out %0d times where %0d readouts were due",
			readouts, N_PHASE * PHASE_CYC);
	end
	for (int ch = 0; ch < `N_CHAN; ch++) begin
		assert (exp_q[ch].size() == 0) else begin
			errors++;
			$display("dac channel %0d is missing %0d frames at the end of the run",
				ch, exp_q[ch].size());
		end
	end
	finish_run(1'b0);
end

endmodule

`default_nettype wire

/* verif/pid_controller_properties.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module pid_controller_properties (
	input logic clk50,
	input logic rst_n,
	input logic adc_convst,
	input logic adc_busy,
	input logic adc_n_cs,
	input logic adc_sclk,
	input logic dac_nsync,
	input logic dac_sclk,
	input logic dac_valid,
	input logic dac_done
);

int fail_cnt = 0;		// failed assertions, summed up by the testbench
logic [7:0] conv_gap;	// clocks since last convst rise, 0 before the first
logic [6:0] sync_len;	// clocks with nsync low
logic       convst_q;

always_ff @(posedge clk50) begin
	if (!rst_n) begin
		conv_gap <= '0;
		sync_len <= '0;
		convst_q <= 1'b0;
	end else begin
		convst_q <= adc_convst;
		if (adc_convst && !convst_q) conv_gap <= 8'd1;
		else if (conv_gap != '0 && conv_gap != 8'hff) conv_gap <= conv_gap + 1'b1;
		sync_len <= dac_nsync ? '0 : sync_len + 1'b1;
	end
end

//////////////////////////////
// adc side
//////////////////////////////

convst_period: assert property (@(posedge clk50) disable iff (!rst_n)
	(adc_convst && !convst_q && conv_gap != '0) |-> conv_gap == 8'(`ADC_CYCLE))
	else begin fail_cnt++; $error("convst rise not %0d clocks after the last", `ADC_CYCLE); end

n_cs_after_busy: assert property (@(posedge clk50) disable iff (!rst_n)
	!adc_n_cs |-> !adc_busy)
	else begin fail_cnt++; $error("adc n_cs low while busy is high"); end

adc_sclk_window: assert property (@(posedge clk50) disable iff (!rst_n)
	(adc_sclk != $past(adc_sclk)) |-> !adc_n_cs)
	else begin fail_cnt++; $error("adc sclk toggles outside the n_cs window"); end

//////////////////////////////
// dac side
//////////////////////////////

dac_sclk_window: assert property (@(posedge clk50) disable iff (!rst_n)
	(dac_sclk != $past(dac_sclk)) |-> !dac_nsync)
	else begin fail_cnt++; $error("dac sclk toggles outside the nsync window"); end

nsync_length: assert property (@(posedge clk50) disable iff (!rst_n)
	$rose(dac_nsync) |-> sync_len == 7'd64)
	else begin fail_cnt++; $error("dac nsync low for %0d clocks", sync_len); end

valid_until_done: assert property (@(posedge clk50) disable iff (!rst_n)
	(dac_valid && !dac_done) |=> dac_valid)
	else begin fail_cnt++; $error("dac word valid dropped before done"); end

valid_after_done: assert property (@(posedge clk50) disable iff (!rst_n)
	dac_done |=> !dac_valid)
	else begin fail_cnt++; $error("dac word valid still high after done"); end

endmodule

bind pid_controller pid_controller_properties props (
	.clk50(clk50), .rst_n(rst_n),
	.adc_convst(adc_convst), .adc_busy(adc_busy), .adc_n_cs(adc_n_cs), .adc_sclk(adc_sclk),
	.dac_nsync(dac_nsync), .dac_sclk(dac_sclk),
	.dac_valid(dac_w.valid), .dac_done(dac_w.done)
);

`default_nettype wire

/* rtl/pid_controller.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module pid_controller (
	input  logic               clk50,		// single 50 MHz clock
	input  logic               rst_n,
	// adc, ad7608
	input  logic               adc_busy,
	input  logic               adc_data_a,
	input  logic               adc_data_b,
	output logic               adc_convst,
	output logic               adc_n_cs,
	output logic               adc_sclk,
	// dac, dac8568
	output logic               dac_nsync,
	output logic               dac_sclk,
	output logic               dac_din,
	// loop settings, static
	input  pid_pkg::sample_t   setpoint,
	input  pid_pkg::coef_t     p_coef,
	input  pid_pkg::coef_t     i_coef,
	input  pid_pkg::coef_t     d_coef,
	input  logic [`W_OSM-1:0]  osm,
	input  logic               lock_en,
	input  pid_pkg::dac_code_t out_min,
	input  pid_pkg::dac_code_t out_max,
	input  pid_pkg::dac_code_t out_init
);

//////////////////////////////
// internal wiring
//////////////////////////////

pid_pkg::sample_t   sample_a;
pid_pkg::sample_t   sample_b;
logic               sample_valid;
pid_pkg::sample_t   ch_sample [`N_CHAN];	// line a -> ch 0, line b -> ch 1
pid_pkg::sample_t   avg [`N_CHAN];
logic [`N_CHAN-1:0] avg_valid;
pid_pkg::dac_code_t code [`N_CHAN];
logic [`N_CHAN-1:0] code_valid;

loop_cfg_if cfg ();
dac_word_if dac_w ();

assign cfg.setpoint = setpoint;
assign cfg.p_coef = p_coef;
assign cfg.i_coef = i_coef;
assign cfg.d_coef = d_coef;
assign cfg.osm = osm;
assign cfg.lock_en = lock_en;
assign cfg.out_min = out_min;
assign cfg.out_max = out_max;
assign cfg.out_init = out_init;

assign ch_sample[0] = sample_a;
assign ch_sample[1] = sample_b;

//////////////////////////////
// modules
//////////////////////////////

adc_reader adc_rd (
	.clk50(clk50), .rst_n(rst_n),
	.adc_busy(adc_busy), .adc_data_a(adc_data_a), .adc_data_b(adc_data_b),
	.adc_convst(adc_convst), .adc_n_cs(adc_n_cs), .adc_sclk(adc_sclk),
	.sample_a(sample_a), .sample_b(sample_b), .sample_valid(sample_valid)
);

// one filter and pid core per channel
for (genvar ch = 0; ch < `N_CHAN; ch++) begin : g_chan
	oversample_filter osf (
		.clk50(clk50), .rst_n(rst_n), .cfg(cfg.filter),
		.sample(ch_sample[ch]), .sample_valid(sample_valid),
		.avg(avg[ch]), .avg_valid(avg_valid[ch])
	);
	pid_core pid (
		.clk50(clk50), .rst_n(rst_n), .cfg(cfg.pid),
		.avg(avg[ch]), .avg_valid(avg_valid[ch]),
		.code(code[ch]), .code_valid(code_valid[ch])
	);
end

dac_instr_queue dac_iq (
	.clk50(clk50), .rst_n(rst_n),
	.code(code), .code_valid(code_valid), .dac(dac_w.queue)
);

dac_controller dac_cntrl (
	.clk50(clk50), .rst_n(rst_n), .dac(dac_w.ctrl),
	.dac_nsync(dac_nsync), .dac_sclk(dac_sclk), .dac_din(dac_din)
);

endmodule

`default_nettype wire

/* rtl/dac_controller.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module dac_controller (
	input  logic     clk50,
	input  logic     rst_n,
	dac_word_if.ctrl dac,
	output logic     dac_nsync,
	output logic     dac_sclk,
	output logic     dac_din
);

pid_pkg::dac_instr_u instr;
logic [31:0]         shreg;	// remaining frame bits, msb next
logic [5:0]          cnt;	// clocks since nsync fell
logic                start;

// frame fields from the queued word
always_comb begin
	instr.fields.prefix = 4'h0;
	instr.fields.command = `DAC_CMD;
	instr.fields.address = dac.chan;
	instr.fields.data = dac.code;
	instr.fields.feature = 4'h0;
end

// done is still high in the cycle before valid drops
assign start = dac_nsync && dac.valid && !dac.done;

//////////////////////////////
// frame timing
//////////////////////////////

// sclk rises with nsync, dac latches din on each falling sclk
always_ff @(posedge clk50) begin
	if (!rst_n) begin
		dac_nsync <= 1'b1;
		dac_sclk <= 1'b0;
		dac_din <= 1'b0;
		cnt <= '0;
		dac.done <= 1'b0;
	end else begin
		dac.done <= 1'b0;
		if (start) begin
			dac_nsync <= 1'b0;
			dac_sclk <= 1'b1;
			dac_din <= instr.raw[31];	// first bit out with the first rising sclk
			cnt <= '0;
		end else if (!dac_nsync) begin
			cnt <= cnt + 1'b1;
			if (cnt == 6'd63) begin	// 32nd falling edge was last clock
				dac_nsync <= 1'b1;
				dac.done <= 1'b1;
			end else if (!cnt[0]) dac_sclk <= 1'b0;
			else begin
				dac_sclk <= 1'b1;
				dac_din <= shreg[31];
			end
		end
	end
end

always_ff @(posedge clk50) begin
	if (start) shreg <= {instr.raw[30:0], 1'b0};
	else if (!dac_nsync && cnt[0]) shreg <= {shreg[30:0], 1'b0};	// advance on rising sclk
end

endmodule

`default_nettype wire

/* rtl/dac_instr_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module dac_instr_queue (
	input  logic               clk50,
	input  logic               rst_n,
	input  pid_pkg::dac_code_t code [`N_CHAN],
	input  logic [`N_CHAN-1:0] code_valid,
	dac_word_if.queue          dac
);

localparam int W_IDX = $clog2(`N_CHAN);

pid_pkg::dac_code_t pend_code [`N_CHAN];	// newest value per channel
logic [`N_CHAN-1:0] pend_flag;
logic [`N_CHAN-1:0] issue_mask;
logic [W_IDX-1:0]   last;	// channel served most recently
logic [W_IDX-1:0]   sel;
logic               found;
logic               issue;

// round robin, search starts one past the last channel served
always_comb begin
	int idx;
	sel = last;
	found = 1'b0;
	for (int k = 1; k <= `N_CHAN; k++) begin
		idx = (int'(last) + k) % `N_CHAN;
		if (!found && pend_flag[idx]) begin
			sel = W_IDX'(idx);
			found = 1'b1;
		end
	end
end

assign issue = !dac.valid && found;
assign issue_mask = issue ? (`N_CHAN)'(1) << sel : '0;

always_ff @(posedge clk50) begin
	if (!rst_n) begin
		pend_flag <= '0;
		last <= W_IDX'(`N_CHAN - 1);	// channel 0 goes first
		dac.valid <= 1'b0;
	end else begin
		pend_flag <= (pend_flag | code_valid) & ~issue_mask;	// flag leaves with the word
		if (issue) begin
			dac.valid <= 1'b1;
			last <= sel;
		end else if (dac.done) dac.valid <= 1'b0;
	end
end

always_ff @(posedge clk50) begin
	for (int ch = 0; ch < `N_CHAN; ch++) begin
		if (code_valid[ch]) pend_code[ch] <= code[ch];	// overwrite, newest wins
	end
	if (issue) begin
		dac.code <= code_valid[sel] ? code[sel] : pend_code[sel];	// bypass a same cycle update
		dac.chan <= pid_pkg::dac_chan_t'(sel);	// channel n -> dac address n
	end
end

endmodule

`default_nettype wire

/* rtl/pid_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module pid_core (
	input  logic               clk50,
	input  logic               rst_n,
	loop_cfg_if.pid            cfg,
	input  pid_pkg::sample_t   avg,
	input  logic               avg_valid,
	output pid_pkg::dac_code_t code,
	output logic               code_valid
);

localparam int W_ERR = `W_SAMPLE + 1;	// setpoint - avg
localparam int W_DIF = `W_SAMPLE + 2;	// err - prev_err

// stage 1
logic signed [W_ERR-1:0]  err;
logic signed [W_ERR-1:0]  err_q;
logic signed [W_ERR-1:0]  prev_err;
logic signed [W_DIF-1:0]  diff_q;
logic signed [`W_ACC-1:0] integ;	// running sum of err
logic                     s1_valid;
logic                     s1_lock;

// stage 2
logic signed [`W_ACC-1:0] p_term;
logic signed [`W_ACC-1:0] i_term;
logic signed [`W_ACC-1:0] d_term;
logic signed [`W_ACC-1:0] pid_sum;
pid_pkg::dac_code_t       clamped;

assign err = cfg.setpoint - avg;

always_ff @(posedge clk50) begin
	if (!rst_n) begin
		s1_valid <= 1'b0;
		s1_lock <= 1'b0;
		integ <= '0;
		prev_err <= '0;
		code_valid <= 1'b0;
	end else begin
		s1_valid <= avg_valid;
		s1_lock <= cfg.lock_en;
		code_valid <= s1_valid;
		if (!cfg.lock_en) begin	// unlocked, history restarts from zero
			integ <= '0;
			prev_err <= '0;
		end else if (avg_valid) begin
			integ <= integ + err;
			prev_err <= err;
		end
	end
end

always_ff @(posedge clk50) begin
	if (avg_valid) begin
		err_q <= err;
		diff_q <= err - prev_err;
	end
	if (s1_valid) code <= s1_lock ? clamped : cfg.out_init;
end

// products wrap at W_ACC bits
always_comb begin
	p_term = cfg.p_coef * err_q;
	i_term = cfg.i_coef * integ;
	d_term = cfg.d_coef * diff_q;
	pid_sum = p_term + i_term + d_term + $signed({1'b0, cfg.out_init});	// offset
	if (pid_sum < $signed({1'b0, cfg.out_min})) clamped = cfg.out_min;
	else if (pid_sum > $signed({1'b0, cfg.out_max})) clamped = cfg.out_max;
	else clamped = pid_sum[`W_DAC-1:0];
end

endmodule

`default_nettype wire

/* rtl/oversample_filter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module oversample_filter (
	input  logic             clk50,
	input  logic             rst_n,
	loop_cfg_if.filter       cfg,
	input  pid_pkg::sample_t sample,
	input  logic             sample_valid,
	output pid_pkg::sample_t avg,
	output logic             avg_valid
);

localparam int W_CNT = (1 << `W_OSM) - 1;	// max count 2^osm - 1
localparam int W_SUM = `W_SAMPLE + W_CNT;	// sum of up to 2^W_CNT samples

logic signed [W_SUM-1:0] acc;
logic signed [W_SUM-1:0] sum_next;
logic [W_CNT-1:0]        cnt;
logic [W_CNT:0]          span;	// 2^osm
logic                    last;	// this sample closes the window

assign sum_next = acc + sample;	// sample sign extended
assign span = (W_CNT + 1)'(1) << cfg.osm;
assign last = ({1'b0, cnt} >= span - 1'b1);	// >= so a smaller osm never stalls

always_ff @(posedge clk50) begin
	if (!rst_n) begin
		acc <= '0;
		cnt <= '0;
		avg_valid <= 1'b0;
	end else begin
		avg_valid <= sample_valid && last;
		if (sample_valid) begin
			if (last) begin	// restart window
				acc <= '0;
				cnt <= '0;
			end else begin
				acc <= sum_next;
				cnt <= cnt + 1'b1;
			end
		end
	end
end

// arithmetic shift divides by 2^osm, osm 0 passes the sample through
always_ff @(posedge clk50) begin
	if (sample_valid && last) avg <= pid_pkg::sample_t'(sum_next >>> cfg.osm);
end

endmodule

`default_nettype wire

/* rtl/adc_reader.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

module adc_reader (
	input  logic             clk50,
	input  logic             rst_n,
	input  logic             adc_busy,
	input  logic             adc_data_a,
	input  logic             adc_data_b,
	output logic             adc_convst,
	output logic             adc_n_cs,
	output logic             adc_sclk,
	output pid_pkg::sample_t sample_a,
	output pid_pkg::sample_t sample_b,
	output logic             sample_valid
);

localparam int W_CYC = $clog2(`ADC_CYCLE);
localparam int W_BIT = $clog2(`W_SAMPLE);

// fsm encoding
localparam logic [2:0] S_IDLE  = 3'd0;
localparam logic [2:0] S_CONV  = 3'd1;	// convst high
localparam logic [2:0] S_WAIT  = 3'd2;	// wait for busy to drop
localparam logic [2:0] S_SHIFT = 3'd3;
localparam logic [2:0] S_DONE  = 3'd4;

logic [2:0]       state;
logic [W_CYC-1:0] cyc_cnt;	// free running conversion period
logic [W_BIT-1:0] bit_cnt;
logic             busy_q;
pid_pkg::sample_t sh_a;
pid_pkg::sample_t sh_b;

//////////////////////////////
// conversion timing
//////////////////////////////

always_ff @(posedge clk50) begin
	if (!rst_n) begin
		cyc_cnt <= W_CYC'(`CONVST_LEN - 1);	// first convst after a full period
		adc_convst <= 1'b0;
	end else begin
		cyc_cnt <= (cyc_cnt == W_CYC'(`ADC_CYCLE - 1)) ? '0 : cyc_cnt + 1'b1;
		adc_convst <= (cyc_cnt == W_CYC'(`ADC_CYCLE - 1)) |
			(cyc_cnt < W_CYC'(`CONVST_LEN - 1));	// high while cyc_cnt 0..CONVST_LEN-1
	end
end

//////////////////////////////
// readout fsm
//////////////////////////////

always_ff @(posedge clk50) begin
	if (!rst_n) begin
		state <= S_IDLE;
		adc_n_cs <= 1'b1;
		adc_sclk <= 1'b0;
		bit_cnt <= '0;
		busy_q <= 1'b0;
		sample_valid <= 1'b0;
	end else begin
		busy_q <= adc_busy;
		sample_valid <= 1'b0;
		case (state)
			S_IDLE: if (cyc_cnt == W_CYC'(`ADC_CYCLE - 1)) state <= S_CONV;
			S_CONV: if (cyc_cnt == W_CYC'(`CONVST_LEN - 1)) state <= S_WAIT;
			S_WAIT: begin
				if (busy_q && !adc_busy) begin	// falling busy, conversion done
					adc_n_cs <= 1'b0;
					bit_cnt <= '0;
					state <= S_SHIFT;
				end
			end
			S_SHIFT: begin
				adc_sclk <= !adc_sclk;	// period of two clocks
				if (adc_sclk) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == W_BIT'(`W_SAMPLE - 1)) state <= S_DONE;
				end
			end
			S_DONE: begin
				adc_n_cs <= 1'b1;
				sample_valid <= 1'b1;	// both channels at once
				state <= S_IDLE;
			end
			default: state <= S_IDLE;
		endcase
	end
end

// data lines sampled as sclk rises, msb first
always_ff @(posedge clk50) begin
	if (state == S_SHIFT && !adc_sclk) begin
		sh_a <= {sh_a[`W_SAMPLE-2:0], adc_data_a};
		sh_b <= {sh_b[`W_SAMPLE-2:0], adc_data_b};
	end
	if (state == S_DONE) begin
		sample_a <= sh_a;
		sample_b <= sh_b;
	end
end

endmodule

`default_nettype wire

/* rtl/dac_word_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one queued dac word
// valid holds with stable code/chan until done, drops the cycle after
interface dac_word_if;

	pid_pkg::dac_code_t code;
	pid_pkg::dac_chan_t chan;
	logic valid;
	logic done;		// single cycle, end of frame

	modport queue (output code, chan, valid, input done);
	modport ctrl (input code, chan, valid, output done);

endinterface

`default_nettype wire

/* rtl/loop_cfg_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pid_params.svh"

// static loop settings, fanned out to every channel
interface loop_cfg_if;

	pid_pkg::sample_t setpoint;
	pid_pkg::coef_t p_coef;
	pid_pkg::coef_t i_coef;
	pid_pkg::coef_t d_coef;
	logic [`W_OSM-1:0] osm;		// average over 2^osm samples
	logic lock_en;				// low -> output held at out_init
	pid_pkg::dac_code_t out_min;
	pid_pkg::dac_code_t out_max;
	pid_pkg::dac_code_t out_init;	// also the output offset when locked

	modport filter (input osm);
	modport pid (input setpoint, p_coef, i_coef, d_coef, lock_en, out_min, out_max, out_init);

endinterface

`default_nettype wire

/* rtl/pid_pkg.sv */
`default_nettype none

`include "pid_params.svh"

package pid_pkg;

	typedef logic signed [`W_SAMPLE-1:0] sample_t;	// adc sample or setpoint
	typedef logic signed [`W_COEF-1:0] coef_t;		// integer pid gain
	typedef logic [`W_DAC-1:0] dac_code_t;			// straight binary dac code
	typedef logic [3:0] dac_chan_t;					// dac8568 address field

	// dac8568 frame, msb goes out first
	typedef struct packed {
		logic [3:0] prefix;		// don't care bits, sent as zero
		logic [3:0] command;
		dac_chan_t address;
		dac_code_t data;
		logic [3:0] feature;	// unused here
	} dac_fields_t;

	// one 32 bit word seen as frame fields or as raw shift word
	typedef union packed {
		dac_fields_t fields;
		logic [31:0] raw;
	} dac_instr_u;

endpackage

`default_nettype wire

/* rtl/pid_params.svh */
`ifndef PID_PARAMS_SVH
`define PID_PARAMS_SVH

// data path widths
`define W_SAMPLE 18
`define W_DAC 16
`define W_COEF 16
`define W_OSM 3
// pid sum and integral, wide enough for i_coef * integral
`define W_ACC 40

// number of servo channels, adc line a -> ch 0, line b -> ch 1
`define N_CHAN 2

// adc timing in clk50 cycles
`define ADC_CYCLE 200
`define CONVST_LEN 4

// dac8568 write to input register and update channel
`define DAC_CMD 4'b0011

`endif
